// File: wmem_params.svh
`ifndef WMEM_PARAMS_SVH
`define WMEM_PARAMS_SVH

// ********************
// weight store geometry
// ********************

// weights per row, also the systolic array dimension.
`define WMEM_LANES 4

// bits per signed weight.
`define WMEM_WEIGHT_WIDTH 8

// global row address bits, the top bit picks the bank.
`define WMEM_ADDR_WIDTH 8

// rows held in each of the two banks.
`define WMEM_BANK_ROWS 128

`endif

// File: wmem_pkg.sv
`default_nettype none

`include "wmem_params.svh"

package wmem_pkg;

	// ********************
	// data and address types
	// ********************

	typedef logic signed [`WMEM_WEIGHT_WIDTH-1:0] weight_t;
	typedef logic [`WMEM_LANES*`WMEM_WEIGHT_WIDTH-1:0] row_t;

	// lane index is 4 * row offset + column.
	typedef logic [`WMEM_LANES*`WMEM_LANES*`WMEM_WEIGHT_WIDTH-1:0] tile_t;

	typedef logic [`WMEM_ADDR_WIDTH-1:0] row_addr_t;
	typedef logic [`WMEM_ADDR_WIDTH-2:0] bank_addr_t;

	typedef enum logic {
		mode_fc  = 1'b0,
		mode_cnn = 1'b1
	} weight_mode_e;

	// ********************
	// request and response bundles
	// ********************

	typedef struct packed {
		logic       en;
		bank_addr_t addr;
		row_t       data;
	} bank_write_t;

	typedef struct packed {
		logic         en;
		bank_addr_t   addr;
		weight_mode_e mode;
	} bank_read_t;

	typedef struct packed {
		logic         valid;
		logic         bank;
		weight_mode_e mode;
	} resp_ctrl_t;

endpackage

`default_nettype wire

// File: weight_access_router.sv
`timescale 1ns/1ns
`default_nettype none

`include "wmem_params.svh"

module weight_access_router (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    wr_en,
	input  wmem_pkg::row_addr_t     wr_addr,
	input  wmem_pkg::row_t          wr_data,
	input  logic                    rd_en,
	input  wmem_pkg::row_addr_t     rd_addr,
	input  wmem_pkg::row_addr_t     weight_memory_pointer,
	input  wmem_pkg::weight_mode_e  mode,
	output wmem_pkg::bank_write_t   wr_req_0,
	output wmem_pkg::bank_write_t   wr_req_1,
	output wmem_pkg::bank_read_t    rd_req_0,
	output wmem_pkg::bank_read_t    rd_req_1,
	output wmem_pkg::resp_ctrl_t    resp
);
	import wmem_pkg::*;

	row_addr_t eff_addr;
	row_addr_t aligned_addr;
	logic      wr_bank;
	logic      rd_bank;

	// ********************
	// read address forming
	// ********************

	// pointer offset wraps modulo the full address space.
	assign eff_addr = rd_addr + weight_memory_pointer;

	// an FC tile starts on a four-row boundary.
	assign aligned_addr = (mode == mode_fc) ?
		(eff_addr & ~row_addr_t'(`WMEM_LANES - 1)) : eff_addr;

	assign wr_bank = wr_addr[`WMEM_ADDR_WIDTH-1];
	assign rd_bank = eff_addr[`WMEM_ADDR_WIDTH-1];

	// ********************
	// bank steering
	// ********************

	always_comb begin
		wr_req_0.en   = wr_en && !wr_bank;
		wr_req_0.addr = wr_addr[`WMEM_ADDR_WIDTH-2:0];
		wr_req_0.data = wr_data;

		wr_req_1.en   = wr_en && wr_bank;
		wr_req_1.addr = wr_addr[`WMEM_ADDR_WIDTH-2:0];
		wr_req_1.data = wr_data;
	end

	always_comb begin
		rd_req_0.en   = rd_en && !rd_bank;
		rd_req_0.addr = aligned_addr[`WMEM_ADDR_WIDTH-2:0];
		rd_req_0.mode = mode;

		rd_req_1.en   = rd_en && rd_bank;
		rd_req_1.addr = aligned_addr[`WMEM_ADDR_WIDTH-2:0];
		rd_req_1.mode = mode;
	end

	// ********************
	// response control
	// ********************

	// bank and mode travel with the read so the former
	// shapes the word of the request that is in flight.
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			resp <= '0;
		end else begin
			resp.valid <= rd_en;
			if (rd_en) begin
				resp.bank <= rd_bank;
				resp.mode <= mode;
			end
		end
	end

endmodule

`default_nettype wire

// File: weight_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "wmem_params.svh"

module weight_bank (
	input  logic                   clk,
	input  wmem_pkg::bank_write_t  wr_req,
	input  wmem_pkg::bank_read_t   rd_req,
	output wmem_pkg::tile_t        rd_rows
);
	import wmem_pkg::*;

	localparam int ROW_W     = `WMEM_LANES * `WMEM_WEIGHT_WIDTH;
	localparam int LANE_BITS = $clog2(`WMEM_LANES);
	localparam int DEPTH     = `WMEM_BANK_ROWS / `WMEM_LANES;
	localparam int IDX_BITS  = $clog2(DEPTH);
	localparam int ADDR_BITS = $bits(bank_addr_t);

	// ********************
	// storage
	// ********************

	// four sub-arrays, row r lives in sub-array r % 4 at index r / 4.
	// an aligned four-row tile then touches every sub-array once.
	row_t mem [0:`WMEM_LANES-1][0:DEPTH-1];

	logic [LANE_BITS-1:0] wr_lo;
	logic [IDX_BITS-1:0]  wr_idx;
	logic [LANE_BITS-1:0] rd_lo;
	logic [IDX_BITS-1:0]  rd_idx;

	assign wr_lo  = wr_req.addr[LANE_BITS-1:0];
	assign wr_idx = wr_req.addr[ADDR_BITS-1:LANE_BITS];
	assign rd_lo  = rd_req.addr[LANE_BITS-1:0];
	assign rd_idx = rd_req.addr[ADDR_BITS-1:LANE_BITS];

	// ********************
	// write port
	// ********************

	always_ff @(posedge clk) begin
		if (wr_req.en) begin
			mem[wr_lo][wr_idx] <= wr_req.data;
		end
	end

	// ********************
	// read port
	// ********************

	// the router clears the low bits for FC, so rd_lo is zero there
	// and slot k holds row base + k.
	// a write to the same row in this cycle is not seen here.
	always_ff @(posedge clk) begin
		if (rd_req.en) begin
			for (int k = 0; k < `WMEM_LANES; k++) begin
				rd_rows[k*ROW_W +: ROW_W] <= mem[k][rd_idx];
			end
			// cnn keeps only slot 0, the rest is don't care.
			if (rd_req.mode == mode_cnn) begin
				rd_rows[ROW_W-1:0] <= mem[rd_lo][rd_idx];
			end
		end
	end

endmodule

`default_nettype wire

// File: weight_word_former.sv
`timescale 1ns/1ns
`default_nettype none

`include "wmem_params.svh"

module weight_word_former (
	input  wmem_pkg::resp_ctrl_t  resp,
	input  wmem_pkg::tile_t       rows_0,
	input  wmem_pkg::tile_t       rows_1,
	output logic                  rd_valid,
	output wmem_pkg::tile_t       read_word
);
	import wmem_pkg::*;

	localparam int W     = `WMEM_WEIGHT_WIDTH;
	localparam int LANES = `WMEM_LANES * `WMEM_LANES;

	tile_t   sel_rows;
	weight_t lane_w;

	// ********************
	// bank select
	// ********************

	assign sel_rows = resp.bank ? rows_1 : rows_0;
	assign rd_valid = resp.valid;

	// ********************
	// output shaping
	// ********************

	// fc passes the whole tile through.
	// cnn keeps the single row in lanes 0 to 3 and zeroes the rest.
	always_comb begin
		read_word = '0;
		lane_w    = '0;
		for (int lane = 0; lane < LANES; lane++) begin
			if (resp.mode == mode_fc || lane < `WMEM_LANES) begin
				lane_w = sel_rows[lane*W +: W];
			end else begin
				lane_w = '0;
			end
			read_word[lane*W +: W] = lane_w;
		end
	end

endmodule

`default_nettype wire

// File: weight_memory.sv
`timescale 1ns/1ns
`default_nettype none

module weight_memory (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    wr_en,
	input  wmem_pkg::row_addr_t     wr_addr,
	input  wmem_pkg::row_t          wr_data,
	input  logic                    rd_en,
	input  wmem_pkg::row_addr_t     rd_addr,
	input  wmem_pkg::row_addr_t     weight_memory_pointer,
	input  wmem_pkg::weight_mode_e  mode,
	output logic                    rd_valid,
	output wmem_pkg::tile_t         read_word
);
	import wmem_pkg::*;

	bank_write_t wr_req_0;
	bank_write_t wr_req_1;
	bank_read_t  rd_req_0;
	bank_read_t  rd_req_1;
	resp_ctrl_t  resp;
	tile_t       rows_0;
	tile_t       rows_1;

	weight_access_router i_router (
		.clk                   (clk),
		.reset                 (reset),
		.wr_en                 (wr_en),
		.wr_addr               (wr_addr),
		.wr_data               (wr_data),
		.rd_en                 (rd_en),
		.rd_addr               (rd_addr),
		.weight_memory_pointer (weight_memory_pointer),
		.mode                  (mode),
		.wr_req_0              (wr_req_0),
		.wr_req_1              (wr_req_1),
		.rd_req_0              (rd_req_0),
		.rd_req_1              (rd_req_1),
		.resp                  (resp)
	);

	// bank 0 holds rows 0 to 127, bank 1 rows 128 to 255.
	weight_bank i_bank_0 (
		.clk     (clk),
		.wr_req  (wr_req_0),
		.rd_req  (rd_req_0),
		.rd_rows (rows_0)
	);

	weight_bank i_bank_1 (
		.clk     (clk),
		.wr_req  (wr_req_1),
		.rd_req  (rd_req_1),
		.rd_rows (rows_1)
	);

	weight_word_former i_former (
		.resp      (resp),
		.rows_0    (rows_0),
		.rows_1    (rows_1),
		.rd_valid  (rd_valid),
		.read_word (read_word)
	);

endmodule

`default_nettype wire

// File: weight_memory_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "wmem_params.svh"

module weight_memory_checker (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    rd_en,
	input  wmem_pkg::weight_mode_e  mode,
	input  logic                    rd_valid,
	input  wmem_pkg::tile_t         read_word
);
	import wmem_pkg::*;

	localparam int ROW_W  = `WMEM_LANES * `WMEM_WEIGHT_WIDTH;
	localparam int TILE_W = `WMEM_LANES * ROW_W;

	// ********************
	// response timing
	// ********************

	// every accepted read answers on the next edge, and nothing else does.
	a_valid_follows_read: assert property (
		@(posedge clk) disable iff (!reset)
		rd_valid == $past(rd_en)
	) else $error("rd_valid does not follow rd_en by one cycle");

	a_valid_low_in_reset: assert property (
		@(posedge clk) !reset |-> !rd_valid
	) else $error("rd_valid high while reset is asserted");

	// ********************
	// response shape
	// ********************

	// a cnn row only fills lanes 0 to 3.
	a_cnn_upper_zero: assert property (
		@(posedge clk) disable iff (!reset)
		(rd_valid && $past(mode) == mode_cnn) |-> (read_word[TILE_W-1:ROW_W] == '0)
	) else $error("cnn response has nonzero lanes above lane 3");

endmodule

bind weight_memory weight_memory_checker i_checker (
	.clk       (clk),
	.reset     (reset),
	.rd_en     (rd_en),
	.mode      (mode),
	.rd_valid  (rd_valid),
	.read_word (read_word)
);

`default_nettype wire

// File: weight_memory_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "wmem_params.svh"

module weight_memory_tb;
	import wmem_pkg::*;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES  = 4;
	localparam int NUM_ROWS     = 256;
	localparam int FC_READS     = 64;
	localparam int PTR_READS    = 64;
	localparam int EDGE_READS   = 4;
	localparam int ALT_READS    = 64;
	localparam int RW_PAIRS     = 16;
	localparam int DRAIN_CYCLES = 8;
	localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + 2 * NUM_ROWS + FC_READS
		+ PTR_READS + EDGE_READS + ALT_READS + 2 * RW_PAIRS + DRAIN_CYCLES;
	localparam int ROW_W = `WMEM_LANES * `WMEM_WEIGHT_WIDTH;

	logic         clk = 1'b0;
	logic         reset;
	logic         wr_en;
	row_addr_t    wr_addr;
	row_t         wr_data;
	logic         rd_en;
	row_addr_t    rd_addr;
	row_addr_t    weight_memory_pointer;
	weight_mode_e mode;
	logic         rd_valid;
	tile_t        read_word;

	row_t        model [0:NUM_ROWS-1];
	tile_t       exp_q [$];
	tile_t       exp_word;
	logic        pend_valid = 1'b0;
	logic [31:0] seed = 32'd82338;

	weight_memory i_weight_memory (
		.clk                   (clk),
		.reset                 (reset),
		.wr_en                 (wr_en),
		.wr_addr               (wr_addr),
		.wr_data               (wr_data),
		.rd_en                 (rd_en),
		.rd_addr               (rd_addr),
		.weight_memory_pointer (weight_memory_pointer),
		.mode                  (mode),
		.rd_valid              (rd_valid),
		.read_word             (read_word)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ********************
	// helpers
	// ********************

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping after the first error");
	endtask

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic next_random(output logic [15:0] value);
		seed  = lcg_step(seed);
		value = seed[31:16];
	endtask

	// cnn gives one model row and fc the aligned tile of four rows.
	function automatic tile_t expected_word(input row_addr_t ra, input row_addr_t ptr,
			input weight_mode_e md);
		row_addr_t eff;
		row_addr_t base;
		tile_t     word;
		eff  = ra + ptr;
		word = '0;
		if (md == mode_cnn) begin
			word[ROW_W-1:0] = model[eff];
		end else begin
			base = {eff[7:2], 2'b00};
			for (int k = 0; k < `WMEM_LANES; k++) begin
				word[k*ROW_W +: ROW_W] = model[base + row_addr_t'(k)];
			end
		end
		return word;
	endfunction

	// reads see the model before this cycle's write lands.
	task automatic drive_cycle(input logic we, input row_addr_t wa, input row_t wd,
			input logic re, input row_addr_t ra, input row_addr_t ptr,
			input weight_mode_e md);
		@(posedge clk);
		#1;
		wr_en                 = we;
		wr_addr               = wa;
		wr_data               = wd;
		rd_en                 = re;
		rd_addr               = ra;
		weight_memory_pointer = ptr;
		mode                  = md;
		if (re) begin
			exp_q.push_back(expected_word(ra, ptr, md));
		end
		if (we) begin
			model[wa] = wd;
		end
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles) drive_cycle(1'b0, '0, '0, 1'b0, '0, '0, mode_cnn);
	endtask

	task automatic random_row(output row_t value);
		logic [15:0] hi;
		logic [15:0] lo;
		next_random(hi);
		next_random(lo);
		value = {hi, lo};
	endtask

	// ********************
	// response monitor
	// ********************

	always @(posedge clk) begin
		pend_valid <= rd_en;
	end

	always @(negedge clk) begin
		assert (rd_valid === pend_valid) else
			report_failure($sformatf("Fail rd_valid expected %h actual %h",
				pend_valid, rd_valid));
		if (pend_valid) begin
			exp_word = exp_q.pop_front();
			assert (read_word === exp_word) else
				report_failure($sformatf("Fail read_word expected %h actual %h",
					exp_word, read_word));
		end
	end

	// ********************
	// stimulus
	// ********************

	initial begin
		logic [15:0] r;
		logic [15:0] p;
		row_t        data;
		row_addr_t   row;
		reset                 = 1'b1;
		wr_en                 = 1'b0;
		wr_addr               = '0;
		wr_data               = '0;
		rd_en                 = 1'b0;
		rd_addr               = '0;
		weight_memory_pointer = '0;
		mode                  = mode_cnn;
		#1;
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b1;
		drive_idle(IDLE_CYCLES);

		for (int i = 0; i < NUM_ROWS; i++) begin
			random_row(data);
			drive_cycle(1'b1, row_addr_t'(i), data, 1'b0, '0, '0, mode_cnn);
		end
		for (int i = 0; i < NUM_ROWS; i++) begin
			drive_cycle(1'b0, '0, '0, 1'b1, row_addr_t'(i), '0, mode_cnn);
		end

		// unaligned addresses hit the same tile as their aligned base.
		for (int i = 0; i < FC_READS; i++) begin
			next_random(r);
			drive_cycle(1'b0, '0, '0, 1'b1, r[7:0], '0, mode_fc);
		end

		for (int i = 0; i < PTR_READS; i++) begin
			next_random(r);
			next_random(p);
			if (p[7:0] == 8'd0) begin
				p[7:0] = 8'd1;
			end
			drive_cycle(1'b0, '0, '0, 1'b1, r[7:0], p[7:0], weight_mode_e'(r[8]));
		end
		drive_cycle(1'b0, '0, '0, 1'b1, 8'd127, 8'd1, mode_cnn);
		drive_cycle(1'b0, '0, '0, 1'b1, 8'd255, 8'd1, mode_cnn);
		drive_cycle(1'b0, '0, '0, 1'b1, 8'd250, 8'd10, mode_fc);
		drive_cycle(1'b0, '0, '0, 1'b1, 8'd120, 8'd20, mode_fc);

		for (int i = 0; i < ALT_READS; i++) begin
			next_random(r);
			next_random(p);
			drive_cycle(1'b0, '0, '0, 1'b1, r[7:0], p[7:0], weight_mode_e'(i % 2));
		end

		// a same-row read and write followed by a read of the new data.
		for (int i = 0; i < RW_PAIRS; i++) begin
			next_random(r);
			row = r[7:0];
			random_row(data);
			drive_cycle(1'b1, row, data, 1'b1, row, '0, mode_cnn);
			drive_cycle(1'b0, '0, '0, 1'b1, row, '0, mode_cnn);
		end

		drive_idle(DRAIN_CYCLES);
		if (exp_q.size() == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			report_failure("reads were left without a response at the end of the run");
		end
	end

	// ********************
	// watchdog
	// ********************

	initial begin
		#((TOTAL_CYCLES + 20) * CLK_PERIOD);
		report_failure("watchdog expired before the tests finished");
	end

endmodule

`default_nettype wire

// File: weight_memory.f
+incdir+.
wmem_pkg.sv
weight_access_router.sv
weight_bank.sv
weight_word_former.sv
weight_memory.sv
weight_memory_checker.sv
weight_memory_tb.sv
